// File: dv/clk_gen.sv
module clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time half_period = 20ns;   // 40 ns period

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

// File: dv/display_checker.sv
`include "display_defs.svh"

module display_checker (
    input logic                     clk,
    input logic                     reset_p,
    input logic                     in_valid,
    input logic                     in_ready,
    input logic [`DISP_VALUE_W-1:0] in_value,
    input display_pkg::disp_op_t    in_op,
    input logic [`DISP_DIGITS-1:0]  com
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // read by the testbench at the end

    // exactly one active-low common at any time
    com_one_active: assert property (@(posedge clk) disable iff (reset_p)
        $countones(~com) == 1)
    else begin
        fail_count++;
        $error("com is %b, not exactly one digit on", com);
    end

    // a waiting request keeps its value and opcode
    request_held: assert property (@(posedge clk) disable iff (reset_p)
        (in_valid && !in_ready) |=> ($stable(in_value) && $stable(in_op)))
    else begin
        fail_count++;
        $error("request changed while in_ready was low");
    end

    ready_after_reset: assert property (@(posedge clk) $fell(reset_p) |-> in_ready)
    else begin
        fail_count++;
        $error("in_ready low in the first cycle after reset");
    end

endmodule

bind display_top display_checker checker_inst (
    .clk      (clk),
    .reset_p  (reset_p),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_value (in_value),
    .in_op    (in_op),
    .com      (com)
);

// File: dv/tb_display.sv
`include "display_defs.svh"

module tb_display;
    timeunit 1ns;
    timeprecision 1ps;

    import display_pkg::*;

    localparam int scan_step  = 1 << `DISP_SCAN_DIV_W;     // clocks per scan tick
    localparam int com_limit  = 6 * scan_step;             // more than one full rotation
    localparam int req_limit  = 32;                        // decimal latency is 14
    localparam int run_limit  = 2 * 20 * (14 + 8 * scan_step);

    logic                     clk, reset_p, in_valid, in_ready;
    logic [`DISP_VALUE_W-1:0] in_value;
    disp_op_t                 in_op;
    logic [7:0]               seg_7;
    logic [`DISP_DIGITS-1:0]  com;
    logic [15:0]              lfsr_q;
    int                       errors, tests_run, tests_failed, checker_fails;

    clk_gen clk_gen_inst (.clk(clk));

    display_top display_top_inst (
        .clk(clk), .reset_p(reset_p), .in_valid(in_valid), .in_ready(in_ready),
        .in_value(in_value), .in_op(in_op), .seg_7(seg_7), .com(com)
    );

    ////////////////////////////////////////
    // reference models
    ////////////////////////////////////////

    // active low abcd_efgp
    function automatic logic [7:0] seg_pattern(input logic [3:0] d);
        case (d)
            4'h0: return 8'b0000_0011;
            4'h1: return 8'b1001_1111;
            4'h2: return 8'b0010_0101;
            4'h3: return 8'b0000_1101;
            4'h4: return 8'b1001_1001;
            4'h5: return 8'b0100_1001;
            4'h6: return 8'b0100_0001;
            4'h7: return 8'b0001_1011;
            4'h8: return 8'b0000_0001;
            4'h9: return 8'b0001_1001;
            4'ha: return 8'b0001_0001;
            4'hb: return 8'b1100_0001;
            4'hc: return 8'b0110_0011;
            4'hd: return 8'b1000_0101;
            4'he: return 8'b0110_0001;
            default: return 8'b0111_0001;
        endcase
    endfunction

    function automatic logic [15:0] expected_digits(input logic [11:0] value, input disp_op_t op);
        int v;
        logic [15:0] d;
        v = int'(value);
        if (op == op_hex) begin
            d = {4'h0, value};                    // top digit is padding
        end
        else begin
            d[3:0]   = 4'(v % 10);                // ones
            d[7:4]   = 4'((v / 10) % 10);
            d[11:8]  = 4'((v / 100) % 10);
            d[15:12] = 4'(v / 1000);
        end
        return d;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [11:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[10:0], lfsr_q[0]};
        end
    endtask

    ////////////////////////////////////////
    // handshake and display helpers
    ////////////////////////////////////////

    task automatic wait_transfer(input string name, output int waited);
        int n;
        waited = -1;
        for (n = 0; n < req_limit; n++) begin
            @(negedge clk);
            if (in_ready) begin
                waited = n;
                break;
            end
        end
        @(posedge clk);                           // transfer edge
        #2;
        in_valid = 1'b0;
        if (waited < 0) begin
            $display("%s: request was never accepted", name);
            errors++;
        end
    endtask

    task automatic wait_ready(input string name);
        int n;
        for (n = 0; n < req_limit && !in_ready; n++) begin
            @(negedge clk);
        end
        if (!in_ready) begin
            $display("%s: in_ready never came back high", name);
            errors++;
        end
    endtask

    task automatic check_display(input string name, input logic [15:0] exp);
        int i, n;
        logic [3:0] pat;
        logic [7:0] want;
        repeat (2) @(negedge clk);                // digit register trails by a clock
        for (i = 0; i < `DISP_DIGITS; i++) begin
            pat = ~(4'b0001 << i);
            for (n = 0; n < com_limit && com !== pat; n++) begin
                @(negedge clk);
            end
            want = seg_pattern(exp[i*4 +: 4]);
            if (com !== pat) begin
                $display("%s: com never showed %b", name, pat);
                errors++;
            end
            else if (seg_7 !== want) begin
                $display("mismatch %s: digit %0d expected %b actual %b", name, i, want, seg_7);
                errors++;
            end
        end
    endtask

    task automatic run_request(input string name, input logic [11:0] value, input disp_op_t op);
        int waited;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_value = value;
        in_op    = op;
        wait_transfer(name, waited);
        if (op == op_dec) begin
            @(negedge clk);
            if (in_ready !== 1'b0) begin
                $display("%s: in_ready stayed high after a decimal transfer", name);
                errors++;
            end
            wait_ready(name);
        end
        else begin
            @(negedge clk);
            if (in_ready !== 1'b1) begin
                $display("%s: in_ready dropped after a hex transfer", name);
                errors++;
            end
        end
        check_display(name, expected_digits(value, op));
    endtask

    task automatic finish_test(input string name, input int start_errs);
        tests_run++;
        if (errors > start_errs) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errs);
        end
        else begin
            $display("test %s: ok", name);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic check_after_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        if (com !== 4'b1110) begin
            $display("mismatch reset: com expected 1110 actual %b", com);
            errors++;
        end
        if (seg_7 !== seg_pattern(4'h0)) begin
            $display("mismatch reset: seg_7 expected %b actual %b", seg_pattern(4'h0), seg_7);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("mismatch reset: in_ready expected 1 actual %b", in_ready);
            errors++;
        end
        finish_test("reset", e0);
    endtask

    task automatic scan_order();
        int e0, n, steps, pos;
        logic [3:0] prev, want;
        e0 = errors;
        prev = com;
        pos = 0;                                  // reset leaves digit 0 on
        steps = 0;
        for (n = 0; n < 10 * scan_step && steps < 8; n++) begin
            @(negedge clk);
            if (com !== prev) begin
                pos = (pos + 1) % `DISP_DIGITS;   // next digit up, 3 wraps to 0
                want = ~(4'b0001 << pos);
                if ($countones(~com) != 1) begin
                    $display("scan: com %b does not have exactly one digit on", com);
                    errors++;
                end
                if (com !== want) begin
                    $display("mismatch scan: com expected %b actual %b", want, com);
                    errors++;
                end
                prev = com;
                steps++;
            end
        end
        if (steps < 8) begin
            $display("scan: only %0d of 8 scan steps seen", steps);
            errors++;
        end
        finish_test("scan", e0);
    endtask

    task automatic hex_display();
        int e0;
        e0 = errors;
        run_request("hex", 12'habc, op_hex);
        finish_test("hex", e0);
    endtask

    task automatic decimal_display();
        int e0;
        e0 = errors;
        run_request("dec 1234", 12'd1234, op_dec);
        run_request("dec 4095", 12'd4095, op_dec);
        run_request("dec 0", 12'd0, op_dec);
        finish_test("decimal", e0);
    endtask

    task automatic back_pressure();
        int e0, waited;
        e0 = errors;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_value = 12'd1234;
        in_op    = op_dec;
        wait_transfer("backpressure", waited);
        in_valid = 1'b1;                          // second request waits at the inputs
        in_value = 12'd987;
        in_op    = op_dec;
        wait_transfer("backpressure", waited);
        if (waited < 10) begin
            $display("backpressure: second request taken after %0d cycles", waited);
            errors++;
        end
        @(negedge clk);
        if (in_ready !== 1'b0) begin
            $display("backpressure: in_ready stayed high after the second transfer");
            errors++;
        end
        wait_ready("backpressure");
        check_display("backpressure", expected_digits(12'd987, op_dec));
        finish_test("backpressure", e0);
    endtask

    task automatic random_requests();
        int e0, k;
        logic [11:0] value, op_bit;
        e0 = errors;
        for (k = 0; k < 10; k++) begin
            take_bits(12, value);
            take_bits(1, op_bit);
            run_request($sformatf("random %0d", k), value, disp_op_t'(op_bit[0]));
        end
        finish_test("random", e0);
    endtask

    initial begin
        reset_p  = 1'b1;
        in_valid = 1'b0;
        in_value = '0;
        in_op    = op_hex;
        lfsr_q   = 16'd43;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #2;
        reset_p = 1'b0;
        check_after_reset();
        scan_order();
        hex_display();
        decimal_display();
        back_pressure();
        random_requests();
        checker_fails = display_top_inst.checker_inst.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, checker_fails);
        if (tests_failed == 0 && errors == 0 && checker_fails == 0) begin
            $display("Verification passed");
        end
        else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (run_limit) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", run_limit);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: hw/bcd_converter.sv
`include "display_defs.svh"

module bcd_converter (
    input  logic clk,
    input  logic reset_p,
    conv_if.converter conv
);
    import display_pkg::*;

    localparam int cnt_w = $clog2(`DISP_VALUE_W);
    localparam int acc_w = `DISP_DIGITS * 4;

    conv_state_t              state;
    logic [cnt_w-1:0]         bit_cnt;
    logic [`DISP_VALUE_W-1:0] shift_q;   // binary value, MSB leaves first
    digits_t                  acc;       // BCD accumulator
    logic [acc_w-1:0]         acc_adj;

    // add three to every digit above four
    function automatic digits_t add3(input digits_t d);
        digits_t r;
        r = d;
        for (int i = 0; i < `DISP_DIGITS; i++) begin
            if (r[i] > 4'd4) begin
                r[i] = r[i] + 4'd3;
            end
        end
        return r;
    endfunction

    // adjusting the cleared accumulator before the first shift changes nothing
    assign acc_adj = add3(acc);

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state   <= st_idle;
            bit_cnt <= '0;
        end
        else begin
            case (state)
                st_idle: begin
                    if (conv.start) begin
                        state   <= st_shift;
                        bit_cnt <= '0;
                    end
                end
                st_shift: begin
                    if (bit_cnt == cnt_w'(`DISP_VALUE_W - 1)) begin
                        state <= st_done;               // twelfth shift
                    end
                    bit_cnt <= bit_cnt + 1'b1;
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // shift and add three datapath
    always_ff @(posedge clk) begin
        if (state == st_idle && conv.start) begin
            shift_q <= conv.bin;
            acc     <= '0;
        end
        else if (state == st_shift) begin
            shift_q <= shift_q << 1;
            acc     <= {acc_adj[acc_w-2:0], shift_q[`DISP_VALUE_W-1]};
        end
    end

    assign conv.done = (state == st_done);
    assign conv.bcd  = acc;

endmodule

// File: hw/conv_if.sv
`include "display_defs.svh"

// one conversion request from the decoder and its BCD result
interface conv_if;

    logic                     start;  // one-cycle pulse, converter idle
    logic [`DISP_VALUE_W-1:0] bin;    // valid with start
    logic                     done;   // one-cycle pulse
    display_pkg::digits_t     bcd;    // valid with done

    modport requester (
        output start,
        output bin,
        input  done,
        input  bcd
    );

    modport converter (
        input  start,
        input  bin,
        output done,
        output bcd
    );

endinterface

// File: hw/digit_scan.sv
`include "display_defs.svh"

module digit_scan (
    input  logic                   clk,
    input  logic                   reset_p,
    input  display_pkg::digits_t   digits,
    output logic [`DISP_DIGITS-1:0] com,
    output display_pkg::digit_t    digit
);
    import display_pkg::*;

    localparam int sel_w = $clog2(`DISP_DIGITS);
    localparam logic [`DISP_DIGITS-1:0] com_rst = ~`DISP_DIGITS'(1); // digit 0 on

    logic [`DISP_SCAN_DIV_W-1:0] clk_div;
    logic                        ff_cur, ff_old;
    logic                        tick;
    logic [`DISP_DIGITS-1:0]     com_next;
    logic [sel_w-1:0]            sel;

    // free-running prescaler
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) clk_div <= '0;
        else clk_div <= clk_div + 1'b1;
    end

    ////////////////////////////////////////
    // rising edge of the prescaler MSB
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            ff_cur <= 1'b0;
            ff_old <= 1'b0;
        end
        else begin
            ff_cur <= clk_div[`DISP_SCAN_DIV_W-1];
            ff_old <= ff_cur;
        end
    end

    assign tick = ff_cur & ~ff_old;

    // 1110 -> 1101 -> 1011 -> 0111
    assign com_next = tick ? {com[`DISP_DIGITS-2:0], com[`DISP_DIGITS-1]} : com;

    // position of the low bit in the next common pattern
    always_comb begin
        sel = '0;
        for (int i = 0; i < `DISP_DIGITS; i++) begin
            if (!com_next[i]) sel = sel_w'(i);
        end
    end

    // digit follows com in the same cycle, and tracks register updates too
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com   <= com_rst;
            digit <= '0;
        end
        else begin
            com   <= com_next;
            digit <= digits[sel];
        end
    end

endmodule

// File: hw/disp_cmd_decode.sv
`include "display_defs.svh"

module disp_cmd_decode (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`DISP_VALUE_W-1:0] in_value,
    input  display_pkg::disp_op_t    in_op,
    conv_if.requester                conv,
    output display_pkg::digits_t     digits
);
    import display_pkg::*;

    // zero digits above the hex nibbles
    localparam int pad_w = `DISP_DIGITS * 4 - `DISP_VALUE_W;

    logic                     busy;     // decimal conversion in flight
    logic                     take;     // transfer cycle
    logic                     start_q;
    logic [`DISP_VALUE_W-1:0] bin_q;

    assign in_ready = ~busy;
    assign take     = in_valid & in_ready;

    ////////////////////////////////////////
    // opcode decode and display register
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            busy    <= 1'b0;
            start_q <= 1'b0;
            digits  <= '0;
        end
        else begin
            start_q <= 1'b0;                            // start is a single pulse
            if (take) begin
                case (in_op)
                    op_hex: begin
                        digits <= {{pad_w{1'b0}}, in_value}; // straight to the low digits
                    end
                    op_dec: begin
                        busy    <= 1'b1;                // hold off the requester
                        start_q <= 1'b1;
                    end
                    default: begin
                        busy <= busy;
                    end
                endcase
            end
            else if (busy && conv.done) begin
                digits <= conv.bcd;                     // result lands the cycle after done
                busy   <= 1'b0;
            end
        end
    end

    // value for the converter, sampled at the transfer
    always_ff @(posedge clk) begin
        if (take && in_op == op_dec) begin
            bin_q <= in_value;
        end
    end

    assign conv.start = start_q;
    assign conv.bin   = bin_q;

endmodule

// File: hw/display_defs.svh
`ifndef DISPLAY_DEFS_SVH
`define DISPLAY_DEFS_SVH

////////////////////////////////////////
// display sizing
////////////////////////////////////////

// binary value handed in by the requester
`define DISP_VALUE_W 12

// number of multiplexed digits on the module
`define DISP_DIGITS 4

// prescaler width, one scan step per 2**W clocks
`define DISP_SCAN_DIV_W 4

`endif

// File: hw/display_pkg.sv
`include "display_defs.svh"

package display_pkg;

    ////////////////////////////////////////
    // request opcodes
    ////////////////////////////////////////

    typedef enum logic {
        op_hex = 1'b0,  // nibbles shown as they are
        op_dec = 1'b1   // value converted to decimal first
    } disp_op_t;

    ////////////////////////////////////////
    // converter FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_shift = 2'd1,
        st_done  = 2'd2
    } conv_state_t;

    // one hex or BCD digit
    typedef logic [3:0] digit_t;

    // digit 0 is the least significant one
    typedef digit_t [`DISP_DIGITS-1:0] digits_t;

endpackage

// File: hw/display_top.sv
`include "display_defs.svh"

module display_top (
    input  logic                     clk,
    input  logic                     reset_p,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`DISP_VALUE_W-1:0] in_value,
    input  display_pkg::disp_op_t    in_op,
    output logic [7:0]               seg_7,
    output logic [`DISP_DIGITS-1:0]  com
);
    import display_pkg::*;

    digits_t disp_digits;   // display register
    digit_t  scan_digit;    // digit under the active common

    conv_if conv_bus ();

    ////////////////////////////////////////
    // decode, convert, scan
    ////////////////////////////////////////

    disp_cmd_decode cmd_inst (
        .clk      (clk),
        .reset_p  (reset_p),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_value (in_value),
        .in_op    (in_op),
        .conv     (conv_bus.requester),
        .digits   (disp_digits)
    );

    bcd_converter conv_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .conv    (conv_bus.converter)
    );

    digit_scan scan_inst (
        .clk     (clk),
        .reset_p (reset_p),
        .digits  (disp_digits),
        .com     (com),
        .digit   (scan_digit)
    );

    seg7_decoder seg_inst (
        .digit (scan_digit),
        .seg_7 (seg_7)
    );

endmodule

// File: hw/seg7_decoder.sv
module seg7_decoder (
    input  display_pkg::digit_t digit,
    output logic [7:0]          seg_7
);
    import display_pkg::*;

    digit_t value;

    assign value = digit;

    // active low, abcd_efgp, point always off
    always_comb begin
        case (value)
            4'h0: seg_7 = 8'b0000_0011;
            4'h1: seg_7 = 8'b1001_1111;
            4'h2: seg_7 = 8'b0010_0101;
            4'h3: seg_7 = 8'b0000_1101;
            4'h4: seg_7 = 8'b1001_1001;
            4'h5: seg_7 = 8'b0100_1001;
            4'h6: seg_7 = 8'b0100_0001;
            4'h7: seg_7 = 8'b0001_1011;
            4'h8: seg_7 = 8'b0000_0001;
            4'h9: seg_7 = 8'b0001_1001;
            4'ha: seg_7 = 8'b0001_0001;  // A
            4'hb: seg_7 = 8'b1100_0001;  // lower case b
            4'hc: seg_7 = 8'b0110_0011;  // C
            4'hd: seg_7 = 8'b1000_0101;  // lower case d
            4'he: seg_7 = 8'b0110_0001;  // E
            4'hf: seg_7 = 8'b0111_0001;  // F
            default: seg_7 = 8'b1111_1111;
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_display \
    -f src.f -o sim_tb_display &&
./obj_dir/sim_tb_display +verilator+error+limit+100 | tee /dev/stderr |
    grep -q "^Verification passed$" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: src.f
+incdir+hw
hw/display_pkg.sv
hw/conv_if.sv
hw/disp_cmd_decode.sv
hw/bcd_converter.sv
hw/digit_scan.sv
hw/seg7_decoder.sv
hw/display_top.sv
dv/clk_gen.sv
dv/display_checker.sv
dv/tb_display.sv
